/* Bender.yml */
package:
  name: exec_top

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/exec_pkg.sv
      - src/rf_if.sv
      - src/clock_gate.sv
      - src/register_file_latch.sv
      - src/exec_alu.sv
      - src/issue_ctrl.sv
      - src/exec_top.sv
  - target: test
    files:
      - verif/tb_exec_top.sv

/* src/clock_gate.sv */
// Clock-gating cell
// Enable latched in the low phase, gated clock is clock AND latched enable
`timescale 1ns/100ps
`default_nettype none

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latched;

  // Transparent while clock low, so enable is stable over the high phase
  always_latch begin
    if (!clk_i) begin
      en_latched <= en_i | test_en_i;
    end
  end

  assign clk_o = clk_i & en_latched;

endmodule

`default_nettype wire

/* src/exec_alu.sv */
// Integer ALU
// Add, subtract, logic ops, shifts and signed compare, purely combinational
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
  input  exec_pkg::xlen_t   a_i,
  input  exec_pkg::xlen_t   b_i,
  input  exec_pkg::alu_op_e op_i,
  output exec_pkg::xlen_t   result_o
);
  import exec_pkg::*;

  logic [4:0] shamt;

  // Shift amount from low bits of b only
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_SLL: result_o = a_i << shamt;
      ALU_SRL: result_o = a_i >> shamt;
      // Sign bit replicated
      ALU_SRA: result_o = xlen_t'($signed(a_i) >>> shamt);
      // 1 or 0
      ALU_SLT: result_o = xlen_t'($signed(a_i) < $signed(b_i));
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/exec_consts.svh */
// Execute block constants
// Data and register-file sizes, plus the RV32I opcode and function codes
// used by the decoder
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath and register file sizes
`define EXEC_XLEN      32
`define EXEC_REG_AW    5
`define EXEC_NUM_REGS  32

// Major opcodes
`define EXEC_OP_REG    7'b0110011
`define EXEC_OP_IMM    7'b0010011

// funct3 selects
`define EXEC_F3_ADD    3'b000
`define EXEC_F3_SLL    3'b001
`define EXEC_F3_SLT    3'b010
`define EXEC_F3_XOR    3'b100
`define EXEC_F3_SR     3'b101
`define EXEC_F3_OR     3'b110
`define EXEC_F3_AND    3'b111

// funct7 for SUB and SRA
`define EXEC_F7_ALT    7'b0100000

`endif

/* src/exec_pkg.sv */
// Execute block types
// Data word, register index, ALU operation and the instruction word union
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  typedef logic [`EXEC_XLEN-1:0]   xlen_t;
  typedef logic [`EXEC_REG_AW-1:0] reg_addr_t;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT
  } alu_op_e;

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same word, two views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

endpackage

`default_nettype wire

/* src/exec_top.sv */
// Execute block top level
// Issue control, ALU and latch register file behind valid/ready ports
`timescale 1ns/100ps
`default_nettype none

module exec_top (
  input  logic                clk_int,
  input  logic                rst_ni,
  input  logic                test_en_i,
  // Instruction channel
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  exec_pkg::instr_u    instr_i,
  // Result channel
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output exec_pkg::reg_addr_t res_rd_o,
  output exec_pkg::xlen_t     res_data_o,
  output logic                res_illegal_o
);
  import exec_pkg::*;

  xlen_t   alu_a;
  xlen_t   alu_b;
  xlen_t   alu_result;
  alu_op_e alu_op;

  rf_if rf_bus ();

  issue_ctrl u_issue_ctrl (
    .clk_i         (clk_int),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .alu_op_o      (alu_op),
    .alu_result_i  (alu_result),
    .rf            (rf_bus.ctrl),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_illegal_o (res_illegal_o)
  );

  exec_alu u_exec_alu (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .op_i     (alu_op),
    .result_o (alu_result)
  );

  register_file_latch u_register_file (
    .clk_i     (clk_int),
    .rst_ni    (rst_ni),
    .test_en_i (test_en_i),
    .rf        (rf_bus.rf)
  );

endmodule

`default_nettype wire

/* src/issue_ctrl.sv */
// Issue and result control
// Decodes the instruction, reads operands, writes back and holds the result
// register behind the two valid/ready handshakes
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module issue_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  exec_pkg::instr_u    instr_i,
  output exec_pkg::xlen_t     alu_a_o,
  output exec_pkg::xlen_t     alu_b_o,
  output exec_pkg::alu_op_e   alu_op_o,
  input  exec_pkg::xlen_t     alu_result_i,
  rf_if.ctrl                  rf,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output exec_pkg::reg_addr_t res_rd_o,
  output exec_pkg::xlen_t     res_data_o,
  output logic                res_illegal_o
);
  import exec_pkg::*;

  logic  accept;
  logic  legal;
  logic  use_imm;
  logic  f7_base;
  logic  f7_alt;
  xlen_t imm_sext;

  // Slot free when empty or draining this cycle
  assign instr_ready_o = ~res_valid_o | res_ready_i;
  assign accept        = instr_valid_i & instr_ready_o;

  assign f7_base  = (instr_i.r_fmt.funct7 == 7'b0);
  assign f7_alt   = (instr_i.r_fmt.funct7 == `EXEC_F7_ALT);
  assign imm_sext = {{(`EXEC_XLEN-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};

  // Opcode and function decode
  always_comb begin
    alu_op_o = ALU_ADD;
    use_imm  = 1'b0;
    legal    = 1'b0;
    case (instr_i.r_fmt.opcode)
      `EXEC_OP_REG: begin
        case (instr_i.r_fmt.funct3)
          `EXEC_F3_ADD: begin
            legal    = f7_base | f7_alt;
            alu_op_o = f7_alt ? ALU_SUB : ALU_ADD;
          end
          `EXEC_F3_SR: begin
            legal    = f7_base | f7_alt;
            alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
          end
          `EXEC_F3_SLL: begin
            legal    = f7_base;
            alu_op_o = ALU_SLL;
          end
          `EXEC_F3_SLT: begin
            legal    = f7_base;
            alu_op_o = ALU_SLT;
          end
          `EXEC_F3_XOR: begin
            legal    = f7_base;
            alu_op_o = ALU_XOR;
          end
          `EXEC_F3_OR: begin
            legal    = f7_base;
            alu_op_o = ALU_OR;
          end
          `EXEC_F3_AND: begin
            legal    = f7_base;
            alu_op_o = ALU_AND;
          end
          default: legal = 1'b0;
        endcase
      end
      `EXEC_OP_IMM: begin
        use_imm = 1'b1;
        // Only ADDI, XORI, ORI, ANDI
        case (instr_i.i_fmt.funct3)
          `EXEC_F3_ADD: begin
            legal    = 1'b1;
            alu_op_o = ALU_ADD;
          end
          `EXEC_F3_XOR: begin
            legal    = 1'b1;
            alu_op_o = ALU_XOR;
          end
          `EXEC_F3_OR: begin
            legal    = 1'b1;
            alu_op_o = ALU_OR;
          end
          `EXEC_F3_AND: begin
            legal    = 1'b1;
            alu_op_o = ALU_AND;
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // Operand fetch, rs2 field is don't-care for immediates
  assign rf.raddr_a = instr_i.r_fmt.rs1;
  assign rf.raddr_b = instr_i.r_fmt.rs2;
  assign alu_a_o    = rf.rdata_a;
  assign alu_b_o    = use_imm ? imm_sext : rf.rdata_b;

  // Write strobe sampled by the RF at the accept edge
  assign rf.we    = accept & legal;
  assign rf.waddr = instr_i.r_fmt.rd;
  assign rf.wdata = alu_result_i;

  // Result valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else if (accept) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  // Result payload, zero data when illegal
  always_ff @(posedge clk_i) begin
    if (accept) begin
      res_rd_o      <= instr_i.r_fmt.rd;
      res_data_o    <= legal ? alu_result_i : '0;
      res_illegal_o <= ~legal;
    end
  end

endmodule

`default_nettype wire

/* src/register_file_latch.sv */
// Latch-based register file
// 31 latch words plus a constant zero word, two combinational read ports,
// one write port through global and per-word clock gates
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module register_file_latch (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  rf_if.rf     rf
);
  import exec_pkg::*;

  xlen_t                     mem [`EXEC_NUM_REGS];
  xlen_t                     wdata_q;
  logic                      clk_we;
  logic [`EXEC_NUM_REGS-1:1] waddr_onehot;
  logic [`EXEC_NUM_REGS-1:1] word_clk;

  // Reads straight from the array
  assign rf.rdata_a = mem[rf.raddr_a];
  assign rf.rdata_b = mem[rf.raddr_b];

  // Global gate, only toggles on a write cycle
  clock_gate u_cg_global (
    .clk_i     (clk_i),
    .en_i      (rf.we),
    .test_en_i (test_en_i),
    .clk_o     (clk_we)
  );

  // Write data held for the latch open phase
  always_ff @(posedge clk_we or negedge rst_ni) begin
    if (!rst_ni) begin
      wdata_q <= '0;
    end else if (rf.we) begin
      wdata_q <= rf.wdata;
    end
  end

  // One-hot word select, word 0 has no slot
  always_comb begin
    for (int i = 1; i < `EXEC_NUM_REGS; i++) begin
      waddr_onehot[i] = rf.we && (rf.waddr == `EXEC_REG_AW'(i));
    end
  end

  // Per-word gates off the global gated clock
  for (genvar w = 1; w < `EXEC_NUM_REGS; w++) begin : g_word_cg
    clock_gate u_cg_word (
      .clk_i     (clk_we),
      .en_i      (waddr_onehot[w]),
      .test_en_i (test_en_i),
      .clk_o     (word_clk[w])
    );
  end

  // Latches open in the high phase after the write edge
  for (genvar w = 1; w < `EXEC_NUM_REGS; w++) begin : g_word_latch
    always_latch begin
      if (word_clk[w]) begin
        mem[w] <= wdata_q;
      end
    end
  end

  // x0 hardwired, writes to it go nowhere
  assign mem[0] = '0;

endmodule

`default_nettype wire

/* src/rf_if.sv */
// Register-file port bundle
// Two read ports and one write port between control and the latch array
`timescale 1ns/100ps
`default_nettype none

interface rf_if;
  import exec_pkg::*;

  // Read ports
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  xlen_t     rdata_a;
  xlen_t     rdata_b;

  // Write port
  reg_addr_t waddr;
  xlen_t     wdata;
  logic      we;

  // Control drives addresses and write data
  modport ctrl (
    output raddr_a, raddr_b, waddr, wdata, we,
    input  rdata_a, rdata_b
  );

  // Register file returns read data
  modport rf (
    input  raddr_a, raddr_b, waddr, wdata, we,
    output rdata_a, rdata_b
  );

endinterface

`default_nettype wire

/* tb.f */
+incdir+src
src/exec_pkg.sv
src/rf_if.sv
src/clock_gate.sv
src/register_file_latch.sv
src/exec_alu.sv
src/issue_ctrl.sv
src/exec_top.sv
verif/tb_exec_top.sv

/* verif/exec_cases.txt */
# Columns: name, instruction word (hex), expected rd (hex),
# expected result data (hex), expected illegal flag (bin)
addi_x1_pos      06400093 01 00000064 0
addi_x2_neg      ff900113 02 fffffff9 0
andi_x3          0f00f193 03 00000060 0
ori_x4           7000e213 04 00000764 0
xori_x5_not      fff14293 05 00000006 0
add_x6           00208333 06 0000005d 0
sub_x7           402083b3 07 0000006b 0
and_x8           0040f433 08 00000064 0
or_x9            0051e4b3 09 00000066 0
xor_x10          00414533 0a fffff89d 0
sll_x11          005095b3 0b 00001900 0
srl_x12          00515633 0c 03ffffff 0
sra_x13          405156b3 0d ffffffff 0
slt_x14_true     00112733 0e 00000001 0
slt_x15_false    0020a7b3 0f 00000000 0
dep_addi_x16     00108813 10 00000065 0
dep_add_x17      010808b3 11 000000ca 0
addi_rd0         00508013 00 00000069 0
read_x0          00100933 12 00000064 0
illegal_opcode   0000a183 03 00000000 1
illegal_funct7   02208333 06 00000000 1
kept_x3          00018993 13 00000060 0
kept_x6          00030a13 14 0000005d 0

/* verif/tb_exec_top.sv */
// Testbench for the execute block
// Runs the cases file in order under random result back-pressure and
// checks every result word, destination and illegal flag
`timescale 1ns/100ps
`default_nettype none

module tb_exec_top;
  import exec_pkg::*;

  localparam int MAX_CASES = 64;

  logic      clk_int;
  logic      rst_ni;
  logic      test_en_i;
  logic      instr_valid_i;
  logic      instr_ready_o;
  instr_u    instr_i;
  logic      res_valid_o;
  logic      res_ready_i;
  reg_addr_t res_rd_o;
  xlen_t     res_data_o;
  logic      res_illegal_o;

  // Case table from the data file
  string       case_name [MAX_CASES];
  logic [31:0] case_instr [MAX_CASES];
  reg_addr_t   case_rd [MAX_CASES];
  xlen_t       case_data [MAX_CASES];
  logic        case_ill [MAX_CASES];
  int          num_cases;

  int          data_errs, rd_errs, flag_errs, other_errs;
  int          cycle_count, cycle_limit;
  logic        cases_loaded;
  logic [31:0] rng;

  exec_top UUT (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_illegal_o (res_illegal_o)
  );

  // 8 ns clock
  initial begin
    clk_int = 1'b0;
    forever #4 clk_int = ~clk_int;
  end

  // xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("ERR %s data expected %h actual %h", name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      $display("ERR %s rd expected %0d actual %0d", name, exp, act);
      rd_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s illegal flag expected %b actual %b", name, exp, act);
      flag_errs++;
    end
  endtask

  // Lines starting with # are comments
  task automatic load_cases();
    int          fd;
    int          rc;
    int          n;
    string       line;
    string       nm;
    logic [31:0] w;
    reg_addr_t   rd;
    xlen_t       d;
    logic        ill;
    num_cases = 0;
    fd = $fopen("verif/exec_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file verif/exec_cases.txt");
      other_errs++;
    end else begin
      while (!$feof(fd) && num_cases < MAX_CASES) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h %b", nm, w, rd, d, ill);
          if (n == 5) begin
            case_name[num_cases]  = nm;
            case_instr[num_cases] = w;
            case_rd[num_cases]    = rd;
            case_data[num_cases]  = d;
            case_ill[num_cases]   = ill;
            num_cases++;
          end
        end
      end
      $fclose(fd);
      if (num_cases == 0) begin
        $display("The cases file holds no usable case");
        other_errs++;
      end
    end
  endtask

  // Run limit scales with the case count
  initial begin
    cycle_count = 0;
    wait (cases_loaded);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_int);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles before all results arrived", cycle_count);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int   issue_idx;
    int   result_idx;
    logic instr_fire;
    logic res_fire;
    rst_ni        = 1'b0;
    test_en_i     = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    res_ready_i   = 1'b0;
    data_errs     = 0;
    rd_errs       = 0;
    flag_errs     = 0;
    other_errs    = 0;
    cases_loaded  = 1'b0;
    rng           = 32'h329c4696;
    issue_idx     = 0;
    result_idx    = 0;
    load_cases();
    cycle_limit  = 8 * num_cases + 50;
    cases_loaded = 1'b1;

    // Reset held for 3 cycles
    repeat (3) @(posedge clk_int);
    #1;
    rst_ni        = 1'b1;
    instr_valid_i = (num_cases > 0);
    instr_i       = case_instr[0];
    res_ready_i   = 1'b1;

    while (result_idx < num_cases) begin
      // Mid-cycle sample, inputs and outputs settled
      @(negedge clk_int);
      instr_fire = instr_valid_i && instr_ready_o;
      res_fire   = res_valid_o && res_ready_i;
      if (res_valid_o && !res_ready_i && instr_ready_o) begin
        $display("Instruction ready was high while a stalled result was held");
        other_errs++;
      end
      if (res_fire && result_idx >= issue_idx) begin
        $display("A result appeared with no instruction left to answer");
        other_errs++;
      end else if (res_fire) begin
        check_rd(case_name[result_idx], case_rd[result_idx], res_rd_o);
        check_data(case_name[result_idx], case_data[result_idx], res_data_o);
        check_flag(case_name[result_idx], case_ill[result_idx], res_illegal_o);
        result_idx++;
      end
      @(posedge clk_int);
      #1;
      if (instr_fire) begin
        issue_idx++;
        if (issue_idx < num_cases) begin
          instr_i = case_instr[issue_idx];
        end else begin
          instr_valid_i = 1'b0;
        end
      end
      // Ready low about one cycle in four
      rng         = xorshift32(rng);
      res_ready_i = (rng[1:0] != 2'b00);
    end

    // No stray result after the last one
    res_ready_i = 1'b1;
    repeat (4) begin
      @(negedge clk_int);
      if (res_valid_o) begin
        $display("An extra result for rd %0d came after the last case", res_rd_o);
        other_errs++;
      end
    end

    $display("Checked %0d of %0d cases, errors data %0d rd %0d flag %0d other %0d",
             result_idx, num_cases, data_errs, rd_errs, flag_errs, other_errs);
    if (data_errs + rd_errs + flag_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
